//--- rv_exec.f
+incdir+src
src/rv_exec_pkg.sv
src/regfile.sv
src/int_unit.sv
src/muldiv_unit.sv
src/wb_arbiter.sv
src/issue.sv
src/rv_exec.sv
verification/rv_exec_asserts.sv
verification/rv_exec_tb.sv

//--- Makefile
TOOL       = verilator
TOP        = rv_exec_tb
FILELIST   = rv_exec.f
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = sim passed

SRCS = $(shell grep -v '^+' $(FILELIST))
HDRS = src/rv_exec_settings.svh

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(HDRS) $(FILELIST)
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The log decides pass or fail, not the simulator exit code
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/rv_exec_tb.sv
`default_nettype none

`include "rv_exec_settings.svh"

module rv_exec_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_exec_pkg::*;

    localparam int TIMEOUT = 200;

    logic           clk = 1'b0;
    logic           rst_n;
    logic           cmd_req;
    exec_op_t       cmd_op;
    reg_idx_t       cmd_rd;
    reg_idx_t       cmd_rs1;
    reg_idx_t       cmd_rs2;
    xlen_t          cmd_imm;
    logic           cmd_ack;
    logic           retire_valid;
    reg_idx_t       retire_rd;
    xlen_t          retire_data;

    // Reference model and results still owed by the DUT
    xlen_t          ref_regs [`RV_NUM_REGS];
    reg_idx_t       pend_rd [$];
    xlen_t          pend_data [$];
    int unsigned    last_retire_cyc [`RV_NUM_REGS];
    int unsigned    cyc = 0;
    logic [63:0]    rng;
    string          cur_test;
    int             errors;
    int             test_start_errors;
    int             tests_done;
    int             tests_failed;

    rv_exec i_dut (
        .clk(clk),
        .rst_n(rst_n),
        .cmd_req(cmd_req),
        .cmd_op(cmd_op),
        .cmd_rd(cmd_rd),
        .cmd_rs1(cmd_rs1),
        .cmd_rs2(cmd_rs2),
        .cmd_imm(cmd_imm),
        .cmd_ack(cmd_ack),
        .retire_valid(retire_valid),
        .retire_rd(retire_rd),
        .retire_data(retire_data)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [63:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 7);
        rng = rng ^ (rng << 17);
        return rng;
    endfunction

    function automatic reg_idx_t rand_src();
        return reg_idx_t'(next_rand());
    endfunction

    // Never x0
    function automatic reg_idx_t rand_dst();
        return reg_idx_t'(next_rand() % 31 + 1);
    endfunction

    function automatic xlen_t expected_result(exec_op_t op, xlen_t a, xlen_t b);
        logic [5:0] sh;
        sh = b[5:0];
        case (op)
            OP_LI:   return b;
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << sh;
            OP_SRL:  return a >> sh;
            OP_SRA:  return $signed(a) >>> sh;
            OP_MUL:  return a * b;
            OP_DIVU: return (b == '0) ? '1 : a / b;
            OP_REMU: return (b == '0) ? a : a % b;
            default: return '0;
        endcase
    endfunction

    function automatic int pending_for(reg_idx_t rd);
        int cnt;
        cnt = 0;
        foreach (pend_rd[i]) begin
            if (pend_rd[i] == rd) cnt++;
        end
        return cnt;
    endfunction

    // Oldest outstanding result for this register
    task automatic match_retire(reg_idx_t rd, xlen_t data);
        int idx;
        idx = -1;
        foreach (pend_rd[i]) begin
            if (idx < 0 && pend_rd[i] == rd) idx = i;
        end
        if (idx < 0) begin
            $display("ERROR %s: retire to x%0d with no command outstanding", cur_test, rd);
            errors++;
        end else begin
            if (pend_data[idx] != data) begin
                $display("MISMATCH %s x%0d expected %h actual %h",
                         cur_test, rd, pend_data[idx], data);
                errors++;
            end
            pend_rd.delete(idx);
            pend_data.delete(idx);
            last_retire_cyc[rd] = cyc;
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && retire_valid) begin
            match_retire(retire_rd, retire_data);
        end
    end

    task automatic abort_run(string why);
        $display("ERROR %s: %s", cur_test, why);
        $display("sim failed");
        $finish;
    endtask

    task automatic start_cmd(exec_op_t op, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2,
                             xlen_t imm);
        xlen_t a;
        xlen_t b;
        xlen_t res;
        a = ref_regs[rs1];
        b = (op == OP_LI) ? imm : ref_regs[rs2];
        res = expected_result(op, a, b);
        if (rd != '0) ref_regs[rd] = res;
        pend_rd.push_back(rd);
        pend_data.push_back(res);
        @(posedge clk);
        #2;
        cmd_op  = op;
        cmd_rd  = rd;
        cmd_rs1 = rs1;
        cmd_rs2 = rs2;
        cmd_imm = imm;
        cmd_req = 1'b1;
    endtask

    task automatic wait_ack(output int unsigned ack_cyc);
        int n;
        n = 0;
        @(negedge clk);
        while (!cmd_ack && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!cmd_ack) abort_run("timeout waiting for cmd_ack");
        ack_cyc = cyc;
    endtask

    task automatic finish_cmd();
        int n;
        n = 0;
        @(posedge clk);
        #2;
        cmd_req = 1'b0;
        @(negedge clk);
        while (cmd_ack && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (cmd_ack) abort_run("cmd_ack did not return low after cmd_req dropped");
    endtask

    task automatic send_cmd(exec_op_t op, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2,
                            xlen_t imm, output int unsigned ack_cyc);
        start_cmd(op, rd, rs1, rs2, imm);
        wait_ack(ack_cyc);
        finish_cmd();
    endtask

    task automatic wait_retired(reg_idx_t rd);
        int n;
        n = 0;
        while (pending_for(rd) != 0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (pending_for(rd) != 0) abort_run($sformatf("missing retire for x%0d", rd));
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (pend_rd.size() != 0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (pend_rd.size() != 0) abort_run("results still missing at end of test");
    endtask

    task automatic begin_test(string name);
        cur_test = name;
        test_start_errors = errors;
    endtask

    task automatic report_test();
        tests_done++;
        if (errors == test_start_errors) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, errors - test_start_errors);
        end
    endtask

    // Multiply or divide with its fixed retire latency
    task automatic run_md(exec_op_t op, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
        int unsigned ack_cyc;
        int unsigned lat;
        send_cmd(op, rd, rs1, rs2, '0, ack_cyc);
        wait_retired(rd);
        lat = last_retire_cyc[rd] - ack_cyc;
        if (lat != `RV_MD_STEPS + 2) begin
            $display("MISMATCH %s latency x%0d expected %0d actual %0d",
                     cur_test, rd, `RV_MD_STEPS + 2, lat);
            errors++;
        end
    endtask

    task automatic test_reset_state();
        int unsigned ack_cyc;
        begin_test("reset_state");
        rst_n = 1'b0;
        repeat (10) begin
            @(negedge clk);
            if (cmd_ack || retire_valid) begin
                $display("ERROR %s: cmd_ack or retire_valid high during reset", cur_test);
                errors++;
            end
        end
        @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        if (cmd_ack || retire_valid) begin
            $display("ERROR %s: cmd_ack or retire_valid high after reset", cur_test);
            errors++;
        end
        send_cmd(OP_LI, 5'd1, 5'd0, 5'd0, next_rand(), ack_cyc);
        wait_retired(5'd1);
        report_test();
    endtask

    task automatic test_alu_ops();
        int unsigned ack_cyc;
        exec_op_t op;
        begin_test("alu_ops");
        for (int r = 1; r < `RV_NUM_REGS; r++) begin
            send_cmd(OP_LI, reg_idx_t'(r), 5'd0, 5'd0, next_rand(), ack_cyc);
        end
        // ADD through SRA
        for (int k = 1; k <= 8; k++) begin
            op = exec_op_t'(k);
            repeat (3) begin
                send_cmd(op, rand_dst(), rand_src(), rand_src(), next_rand(), ack_cyc);
            end
        end
        wait_drain();
        report_test();
    endtask

    task automatic test_muldiv_ops();
        int unsigned ack_cyc;
        xlen_t shift;
        xlen_t divisor;
        begin_test("muldiv_ops");
        repeat (2) begin
            send_cmd(OP_LI, 5'd10, 5'd0, 5'd0, next_rand(), ack_cyc);
            // Divisor of random size, never zero
            shift = next_rand();
            divisor = (next_rand() >> shift[5:0]) | 64'd1;
            send_cmd(OP_LI, 5'd11, 5'd0, 5'd0, divisor, ack_cyc);
            run_md(OP_MUL, 5'd12, 5'd10, 5'd11);
            run_md(OP_DIVU, 5'd13, 5'd10, 5'd11);
            run_md(OP_REMU, 5'd14, 5'd10, 5'd11);
        end
        // x0 as divisor
        run_md(OP_DIVU, 5'd15, 5'd10, 5'd0);
        run_md(OP_REMU, 5'd16, 5'd10, 5'd0);
        report_test();
    endtask

    task automatic test_dependency();
        int unsigned ack_cyc;
        int unsigned add_ack;
        begin_test("dependency");
        send_cmd(OP_LI, 5'd5, 5'd0, 5'd0, next_rand(), ack_cyc);
        send_cmd(OP_LI, 5'd6, 5'd0, 5'd0, (next_rand() >> 40) | 64'd1, ack_cyc);
        send_cmd(OP_DIVU, 5'd7, 5'd5, 5'd6, '0, ack_cyc);
        // Reads the quotient, so it waits behind the divide
        send_cmd(OP_ADD, 5'd8, 5'd7, 5'd5, '0, add_ack);
        if (pending_for(5'd7) != 0 || add_ack <= last_retire_cyc[7]) begin
            $display("ERROR %s: ADD was issued before the divide retired", cur_test);
            errors++;
        end
        wait_drain();
        report_test();
    endtask

    task automatic test_overlap();
        int unsigned ack_cyc;
        begin_test("overlap");
        send_cmd(OP_MUL, 5'd20, 5'd5, 5'd6, '0, ack_cyc);
        send_cmd(OP_ADD, 5'd21, 5'd5, 5'd6, '0, ack_cyc);
        send_cmd(OP_SUB, 5'd22, 5'd6, 5'd5, '0, ack_cyc);
        send_cmd(OP_XOR, 5'd23, 5'd5, 5'd6, '0, ack_cyc);
        send_cmd(OP_SRA, 5'd24, 5'd5, 5'd6, '0, ack_cyc);
        wait_retired(5'd21);
        wait_retired(5'd22);
        wait_retired(5'd23);
        wait_retired(5'd24);
        if (pending_for(5'd20) == 0) begin
            $display("ERROR %s: MUL retired before the integer operations", cur_test);
            errors++;
        end
        wait_drain();
        report_test();
    endtask

    task automatic test_handshake();
        int unsigned ack_cyc;
        begin_test("handshake");
        send_cmd(OP_DIVU, 5'd25, 5'd5, 5'd6, '0, ack_cyc);
        // Muldiv unit still busy, so this one stalls
        start_cmd(OP_REMU, 5'd26, 5'd5, 5'd6, '0);
        repeat (10) begin
            @(negedge clk);
            if (cmd_ack) begin
                $display("ERROR %s: cmd_ack rose while the command was stalled", cur_test);
                errors++;
            end
        end
        wait_ack(ack_cyc);
        finish_cmd();
        wait_drain();
        report_test();
    endtask

    initial begin
        rst_n   = 1'b0;
        cmd_req = 1'b0;
        cmd_op  = OP_LI;
        cmd_rd  = '0;
        cmd_rs1 = '0;
        cmd_rs2 = '0;
        cmd_imm = '0;
        rng     = 64'd90123;
        errors  = 0;
        tests_done = 0;
        tests_failed = 0;
        test_start_errors = 0;
        cur_test = "init";
        foreach (ref_regs[i]) begin
            ref_regs[i] = '0;
            last_retire_cyc[i] = 0;
        end

        test_reset_state();
        test_alu_ops();
        test_muldiv_ops();
        test_dependency();
        test_overlap();
        test_handshake();

        if (i_dut.i_asserts.assert_errors != 0) begin
            $display("ERROR: %0d assertion failures", i_dut.i_asserts.assert_errors);
            errors += i_dut.i_asserts.assert_errors;
        end
        $display("tests %0d, failed %0d, errors %0d", tests_done, tests_failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/rv_exec_asserts.sv
`default_nettype none

module rv_exec_asserts (
    input logic clk,
    input logic rst_n,
    input logic cmd_req,
    input logic cmd_ack,
    input logic retire_valid,
    input logic int_wb_ready,
    input logic md_wb_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    int assert_errors = 0;

    // Ack drops only once the request is gone
    ack_falls_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(cmd_ack) |-> !$past(cmd_req))
        else begin
            $error("cmd_ack fell while cmd_req was still high");
            assert_errors++;
        end

    ack_rises_with_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cmd_ack) |-> cmd_req)
        else begin
            $error("cmd_ack rose without cmd_req");
            assert_errors++;
        end

    retire_idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !retire_valid)
        else begin
            $error("retire_valid high right after reset");
            assert_errors++;
        end

    // Only one unit owns the write port
    single_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(int_wb_ready && md_wb_ready))
        else begin
            $error("both writeback offers granted at once");
            assert_errors++;
        end

endmodule

bind rv_exec rv_exec_asserts i_asserts (
    .clk(clk),
    .rst_n(rst_n),
    .cmd_req(cmd_req),
    .cmd_ack(cmd_ack),
    .retire_valid(retire_valid),
    .int_wb_ready(int_wb_ready),
    .md_wb_ready(md_wb_ready)
);

`default_nettype wire

//--- src/rv_exec.sv
`default_nettype none

`include "rv_exec_settings.svh"

module rv_exec (
    input  logic                    clk,
    input  logic                    rst_n,
    // Command port, four-phase req/ack
    input  logic                    cmd_req,
    input  rv_exec_pkg::exec_op_t   cmd_op,
    input  rv_exec_pkg::reg_idx_t   cmd_rd,
    input  rv_exec_pkg::reg_idx_t   cmd_rs1,
    input  rv_exec_pkg::reg_idx_t   cmd_rs2,
    input  rv_exec_pkg::xlen_t      cmd_imm,
    output logic                    cmd_ack,
    // Retire port
    output logic                    retire_valid,
    output rv_exec_pkg::reg_idx_t   retire_rd,
    output rv_exec_pkg::xlen_t      retire_data
);
    import rv_exec_pkg::*;

    // Register file
    reg_idx_t   rs_a_idx;
    reg_idx_t   rs_b_idx;
    xlen_t      rs_a_data;
    xlen_t      rs_b_data;
    logic       rf_wen;
    reg_idx_t   rf_wdst;
    xlen_t      rf_wdata;

    // Issue to integer unit
    logic       int_valid;
    logic       int_ready;
    exec_op_t   int_op;
    reg_idx_t   int_rd;
    xlen_t      int_a;
    xlen_t      int_b;

    // Issue to muldiv unit
    logic       md_valid;
    logic       md_ready;
    exec_op_t   md_op;
    reg_idx_t   md_rd;
    xlen_t      md_a;
    xlen_t      md_b;

    // Unit results to writeback
    logic       int_wb_valid;
    logic       int_wb_ready;
    reg_idx_t   int_wb_rd;
    xlen_t      int_wb_data;
    logic       md_wb_valid;
    logic       md_wb_ready;
    reg_idx_t   md_wb_rd;
    xlen_t      md_wb_data;

    issue i_issue (
        .clk(clk),
        .rst_n(rst_n),
        .cmd_req(cmd_req),
        .cmd_op(cmd_op),
        .cmd_rd(cmd_rd),
        .cmd_rs1(cmd_rs1),
        .cmd_rs2(cmd_rs2),
        .cmd_imm(cmd_imm),
        .cmd_ack(cmd_ack),
        .rs_a_idx(rs_a_idx),
        .rs_b_idx(rs_b_idx),
        .rs_a_data(rs_a_data),
        .rs_b_data(rs_b_data),
        .int_valid(int_valid),
        .int_ready(int_ready),
        .int_op(int_op),
        .int_rd(int_rd),
        .int_a(int_a),
        .int_b(int_b),
        .md_valid(md_valid),
        .md_ready(md_ready),
        .md_op(md_op),
        .md_rd(md_rd),
        .md_a(md_a),
        .md_b(md_b),
        // Scoreboard release
        .retire_valid(retire_valid),
        .retire_rd(retire_rd)
    );

    regfile i_regfile (
        .clk(clk),
        .rst_n(rst_n),
        .rs_a_idx(rs_a_idx),
        .rs_b_idx(rs_b_idx),
        .rs_a_data(rs_a_data),
        .rs_b_data(rs_b_data),
        .rf_wen(rf_wen),
        .rf_wdst(rf_wdst),
        .rf_wdata(rf_wdata)
    );

    int_unit i_int_unit (
        .clk(clk),
        .rst_n(rst_n),
        .int_valid(int_valid),
        .int_ready(int_ready),
        .int_op(int_op),
        .int_rd(int_rd),
        .int_a(int_a),
        .int_b(int_b),
        .int_wb_valid(int_wb_valid),
        .int_wb_ready(int_wb_ready),
        .int_wb_rd(int_wb_rd),
        .int_wb_data(int_wb_data)
    );

    muldiv_unit i_muldiv_unit (
        .clk(clk),
        .rst_n(rst_n),
        .md_valid(md_valid),
        .md_ready(md_ready),
        .md_op(md_op),
        .md_rd(md_rd),
        .md_a(md_a),
        .md_b(md_b),
        .md_wb_valid(md_wb_valid),
        .md_wb_ready(md_wb_ready),
        .md_wb_rd(md_wb_rd),
        .md_wb_data(md_wb_data)
    );

    wb_arbiter i_wb_arbiter (
        .clk(clk),
        .rst_n(rst_n),
        .int_wb_valid(int_wb_valid),
        .int_wb_ready(int_wb_ready),
        .int_wb_rd(int_wb_rd),
        .int_wb_data(int_wb_data),
        .md_wb_valid(md_wb_valid),
        .md_wb_ready(md_wb_ready),
        .md_wb_rd(md_wb_rd),
        .md_wb_data(md_wb_data),
        .rf_wen(rf_wen),
        .rf_wdst(rf_wdst),
        .rf_wdata(rf_wdata),
        .retire_valid(retire_valid),
        .retire_rd(retire_rd),
        .retire_data(retire_data)
    );

endmodule

`default_nettype wire

//--- src/issue.sv
`default_nettype none

`include "rv_exec_settings.svh"

module issue (
    input  logic                    clk,
    input  logic                    rst_n,
    // Command port
    input  logic                    cmd_req,
    input  rv_exec_pkg::exec_op_t   cmd_op,
    input  rv_exec_pkg::reg_idx_t   cmd_rd,
    input  rv_exec_pkg::reg_idx_t   cmd_rs1,
    input  rv_exec_pkg::reg_idx_t   cmd_rs2,
    input  rv_exec_pkg::xlen_t      cmd_imm,
    output logic                    cmd_ack,
    // Register file read
    output rv_exec_pkg::reg_idx_t   rs_a_idx,
    output rv_exec_pkg::reg_idx_t   rs_b_idx,
    input  rv_exec_pkg::xlen_t      rs_a_data,
    input  rv_exec_pkg::xlen_t      rs_b_data,
    // To integer unit
    output logic                    int_valid,
    input  logic                    int_ready,
    output rv_exec_pkg::exec_op_t   int_op,
    output rv_exec_pkg::reg_idx_t   int_rd,
    output rv_exec_pkg::xlen_t      int_a,
    output rv_exec_pkg::xlen_t      int_b,
    // To muldiv unit
    output logic                    md_valid,
    input  logic                    md_ready,
    output rv_exec_pkg::exec_op_t   md_op,
    output rv_exec_pkg::reg_idx_t   md_rd,
    output rv_exec_pkg::xlen_t      md_a,
    output rv_exec_pkg::xlen_t      md_b,
    // From retire
    input  logic                    retire_valid,
    input  rv_exec_pkg::reg_idx_t   retire_rd
);
    import rv_exec_pkg::*;

    logic [`RV_NUM_REGS-1:0] busy;
    logic                    ack_hold;
    logic                    to_md;
    logic                    uses_src;
    logic                    hazard;
    logic                    can_issue;
    logic                    dispatch;

    assign to_md    = is_muldiv_op(cmd_op);
    // LI takes its value from the immediate only
    assign uses_src = (cmd_op != OP_LI);
    assign hazard   = busy[cmd_rd] || (uses_src && (busy[cmd_rs1] || busy[cmd_rs2]));

    // One command per req/ack cycle
    assign can_issue = cmd_req && !ack_hold && !hazard;
    assign int_valid = can_issue && !to_md;
    assign md_valid  = can_issue && to_md;
    assign dispatch  = (int_valid && int_ready) || (md_valid && md_ready);

    // Ack rises with the dispatch and stays up until req drops
    assign cmd_ack = dispatch || ack_hold;

    // Operand read
    assign rs_a_idx = cmd_rs1;
    assign rs_b_idx = cmd_rs2;

    assign int_op = cmd_op;
    assign int_rd = cmd_rd;
    assign int_a  = rs_a_data;
    assign int_b  = uses_src ? rs_b_data : cmd_imm;

    assign md_op = cmd_op;
    assign md_rd = cmd_rd;
    assign md_a  = rs_a_data;
    assign md_b  = rs_b_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_hold <= 1'b0;
        end else if (dispatch) begin
            ack_hold <= 1'b1;
        end else if (!cmd_req) begin
            ack_hold <= 1'b0;
        end
    end

    // Scoreboard, x0 never waits for a result
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            if (retire_valid) begin
                busy[retire_rd] <= 1'b0;
            end
            if (dispatch && (cmd_rd != '0)) begin
                busy[cmd_rd] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/wb_arbiter.sv
`default_nettype none

`include "rv_exec_settings.svh"

module wb_arbiter (
    input  logic                    clk,
    input  logic                    rst_n,
    // From integer unit
    input  logic                    int_wb_valid,
    output logic                    int_wb_ready,
    input  rv_exec_pkg::reg_idx_t   int_wb_rd,
    input  rv_exec_pkg::xlen_t      int_wb_data,
    // From muldiv unit
    input  logic                    md_wb_valid,
    output logic                    md_wb_ready,
    input  rv_exec_pkg::reg_idx_t   md_wb_rd,
    input  rv_exec_pkg::xlen_t      md_wb_data,
    // Register file write port
    output logic                    rf_wen,
    output rv_exec_pkg::reg_idx_t   rf_wdst,
    output rv_exec_pkg::xlen_t      rf_wdata,
    // Retire port
    output logic                    retire_valid,
    output rv_exec_pkg::reg_idx_t   retire_rd,
    output rv_exec_pkg::xlen_t      retire_data
);

    // Muldiv first, so its latency stays fixed
    assign md_wb_ready  = md_wb_valid;
    assign int_wb_ready = int_wb_valid && !md_wb_valid;

    assign rf_wen   = md_wb_valid || int_wb_valid;
    assign rf_wdst  = md_wb_valid ? md_wb_rd : int_wb_rd;
    assign rf_wdata = md_wb_valid ? md_wb_data : int_wb_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= rf_wen;
        end
    end

    // Retire record mirrors the granted write
    always_ff @(posedge clk) begin
        if (rf_wen) begin
            retire_rd   <= rf_wdst;
            retire_data <= rf_wdata;
        end
    end

endmodule

`default_nettype wire

//--- src/muldiv_unit.sv
`default_nettype none

`include "rv_exec_settings.svh"

module muldiv_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    // From issue
    input  logic                    md_valid,
    output logic                    md_ready,
    input  rv_exec_pkg::exec_op_t   md_op,
    input  rv_exec_pkg::reg_idx_t   md_rd,
    input  rv_exec_pkg::xlen_t      md_a,
    input  rv_exec_pkg::xlen_t      md_b,
    // To writeback
    output logic                    md_wb_valid,
    input  logic                    md_wb_ready,
    output rv_exec_pkg::reg_idx_t   md_wb_rd,
    output rv_exec_pkg::xlen_t      md_wb_data
);
    import rv_exec_pkg::*;

    localparam int CNT_W = $clog2(`RV_MD_STEPS);

    typedef enum logic [1:0] {
        MD_IDLE,
        MD_RUN,
        MD_DONE
    } md_state_t;

    md_state_t          state;
    logic [CNT_W-1:0]   cnt;
    logic               div_zero;
    logic               accept;
    exec_op_t           op_q;
    // Product or remainder
    xlen_t              acc;
    // Multiplier, or dividend shifting out while quotient shifts in
    xlen_t              sreg;
    // Multiplicand or divisor
    xlen_t              opnd;
    logic [`RV_XLEN:0]  rem_shift;
    logic [`RV_XLEN:0]  rem_diff;

    assign md_ready    = (state == MD_IDLE);
    assign accept      = md_valid && md_ready;
    assign md_wb_valid = (state == MD_DONE);
    assign md_wb_data  = (op_q == OP_DIVU) ? sreg : acc;

    // Restoring division step, top bit of the difference is the borrow
    assign rem_shift = {acc, sreg[`RV_XLEN-1]};
    assign rem_diff  = rem_shift - {1'b0, opnd};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= MD_IDLE;
            cnt      <= '0;
            div_zero <= 1'b0;
        end else begin
            case (state)
                MD_IDLE: begin
                    if (accept) begin
                        state    <= MD_RUN;
                        cnt      <= CNT_W'(`RV_MD_STEPS - 1);
                        div_zero <= (md_op != OP_MUL) && (md_b == '0);
                    end
                end
                MD_RUN: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == '0) begin
                        state <= MD_DONE;
                    end
                end
                MD_DONE: begin
                    if (md_wb_ready) begin
                        state <= MD_IDLE;
                    end
                end
                default: state <= MD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q     <= md_op;
            md_wb_rd <= md_rd;
            opnd     <= (md_op == OP_MUL) ? md_a : md_b;
            if (md_op == OP_MUL) begin
                acc  <= '0;
                sreg <= md_b;
            end else if (md_b == '0) begin
                // Final quotient and remainder known up front
                acc  <= md_a;
                sreg <= '1;
            end else begin
                acc  <= '0;
                sreg <= md_a;
            end
        end else if ((state == MD_RUN) && !div_zero) begin
            if (op_q == OP_MUL) begin
                if (sreg[0]) begin
                    acc <= acc + opnd;
                end
                sreg <= sreg >> 1;
                opnd <= opnd << 1;
            end else if (!rem_diff[`RV_XLEN]) begin
                acc  <= rem_diff[`RV_XLEN-1:0];
                sreg <= {sreg[`RV_XLEN-2:0], 1'b1};
            end else begin
                acc  <= rem_shift[`RV_XLEN-1:0];
                sreg <= {sreg[`RV_XLEN-2:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

//--- src/int_unit.sv
`default_nettype none

`include "rv_exec_settings.svh"

module int_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    // From issue
    input  logic                    int_valid,
    output logic                    int_ready,
    input  rv_exec_pkg::exec_op_t   int_op,
    input  rv_exec_pkg::reg_idx_t   int_rd,
    input  rv_exec_pkg::xlen_t      int_a,
    input  rv_exec_pkg::xlen_t      int_b,
    // To writeback
    output logic                    int_wb_valid,
    input  logic                    int_wb_ready,
    output rv_exec_pkg::reg_idx_t   int_wb_rd,
    output rv_exec_pkg::xlen_t      int_wb_data
);
    import rv_exec_pkg::*;

    localparam int SHAMT_W = $clog2(`RV_XLEN);

    logic [SHAMT_W-1:0] shamt;
    xlen_t              alu_res;
    logic               accept;

    assign shamt = int_b[SHAMT_W-1:0];

    always_comb begin
        case (int_op)
            OP_LI:   alu_res = int_b;
            OP_ADD:  alu_res = int_a + int_b;
            OP_SUB:  alu_res = int_a - int_b;
            OP_AND:  alu_res = int_a & int_b;
            OP_OR:   alu_res = int_a | int_b;
            OP_XOR:  alu_res = int_a ^ int_b;
            OP_SLL:  alu_res = int_a << shamt;
            OP_SRL:  alu_res = int_a >> shamt;
            OP_SRA:  alu_res = $signed(int_a) >>> shamt;
            default: alu_res = '0;
        endcase
    end

    // Stall new work while the held result waits for the write port
    assign int_ready = !int_wb_valid || int_wb_ready;
    assign accept    = int_valid && int_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_wb_valid <= 1'b0;
        end else if (accept) begin
            int_wb_valid <= 1'b1;
        end else if (int_wb_ready) begin
            int_wb_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            int_wb_rd   <= int_rd;
            int_wb_data <= alu_res;
        end
    end

endmodule

`default_nettype wire

//--- src/regfile.sv
`default_nettype none

`include "rv_exec_settings.svh"

module regfile (
    input  logic                    clk,
    input  logic                    rst_n,
    // Read ports
    input  logic [`RV_REG_AW-1:0]   rs_a_idx,
    input  logic [`RV_REG_AW-1:0]   rs_b_idx,
    output logic [`RV_XLEN-1:0]     rs_a_data,
    output logic [`RV_XLEN-1:0]     rs_b_data,
    // Write port
    input  logic                    rf_wen,
    input  logic [`RV_REG_AW-1:0]   rf_wdst,
    input  logic [`RV_XLEN-1:0]     rf_wdata
);

    // No storage behind x0
    logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_wen && (rf_wdst != '0)) begin
            regs[rf_wdst] <= rf_wdata;
        end
    end

    assign rs_a_data = (rs_a_idx == '0) ? '0 : regs[rs_a_idx];
    assign rs_b_data = (rs_b_idx == '0) ? '0 : regs[rs_b_idx];

endmodule

`default_nettype wire

//--- src/rv_exec_pkg.sv
`default_nettype none

`include "rv_exec_settings.svh"

package rv_exec_pkg;

    typedef logic [`RV_XLEN-1:0] xlen_t;
    typedef logic [`RV_REG_AW-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        OP_LI   = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_SLL  = 4'd6,
        OP_SRL  = 4'd7,
        OP_SRA  = 4'd8,
        OP_MUL  = 4'd9,
        OP_DIVU = 4'd10,
        OP_REMU = 4'd11
    } exec_op_t;

    // Opcodes handled by the iterative unit
    function automatic logic is_muldiv_op(exec_op_t op);
        return (op == OP_MUL) || (op == OP_DIVU) || (op == OP_REMU);
    endfunction

endpackage

`default_nettype wire

//--- src/rv_exec_settings.svh
`ifndef RV_EXEC_SETTINGS_SVH
`define RV_EXEC_SETTINGS_SVH

// Datapath width of the execution back end
`define RV_XLEN 64

// Architectural registers, x0 included
`define RV_NUM_REGS 32

// Index width for RV_NUM_REGS registers
`define RV_REG_AW 5

// One product or quotient bit per step
`define RV_MD_STEPS `RV_XLEN

`endif
